/* rtl/chirp_dsp_pkg.sv */
package chirp_dsp_pkg;

  // one converter sample, two's complement
  typedef logic signed [15:0] sample_t;

  // packed i/q pair, i sits in 31:16
  typedef logic [31:0] iq_t;

  // phase accumulator and frequency words
  typedef logic [31:0] tuning_word_t;

  // chirp sequencing
  typedef enum logic [1:0] {
    CHIRP_IDLE   = 2'd0,
    CHIRP_READY  = 2'd1,
    CHIRP_ACTIVE = 2'd2,
    CHIRP_DONE   = 2'd3
  } chirp_state_t;

  // samples come from the top phase bits
  localparam int SAMPLE_LSB = 16;

  // q leads i by a quarter turn
  localparam logic [15:0] QUARTER_TURN = 16'h4000;

endpackage

/* rtl/capture_pkg.sv */
package capture_pkg;

  // source select for one 32-bit half of a capture word
  typedef enum logic [1:0] {
    ROUTE_ADC_IQ     = 2'd0,
    ROUTE_DAC_IQ     = 2'd1,
    ROUTE_ADC_COUNT  = 2'd2,
    ROUTE_GLBL_COUNT = 2'd3
  } route_sel_t;

  // one half of a capture word, also the control word
  typedef logic [31:0] half_word_t;

  // upper half in 63:32
  typedef logic [63:0] capture_word_t;

  // sample and cycle counters
  typedef logic [31:0] counter_t;

  // route field positions in the control word
  localparam int ROUTE_LO_LSB = 0;
  localparam int ROUTE_HI_LSB = 4;

endpackage

/* rtl/chirp_dds_gen.sv */
`timescale 1ns/1ps

module chirp_dds_gen #(
  parameter int DDS_LATENCY = 2
) (
  input  logic                        clk_245_76MHz,
  input  logic                        cpu_reset,
  input  logic                        chirp_init_i,
  input  logic                        chirp_enable_i,
  input  chirp_dsp_pkg::tuning_word_t freq_offset_i,
  input  chirp_dsp_pkg::tuning_word_t tuning_coeff_i,
  input  capture_pkg::counter_t       count_max_i,
  output chirp_dsp_pkg::sample_t      dds_i_o,
  output chirp_dsp_pkg::sample_t      dds_q_o,
  output logic                        dds_valid_o,
  output logic                        chirp_ready_o,
  output logic                        chirp_active_o,
  output logic                        chirp_done_o
);

  import chirp_dsp_pkg::*;
  import capture_pkg::*;

  chirp_state_t state_q;
  counter_t     sample_cnt_q;
  tuning_word_t phase_q;
  tuning_word_t tuning_q;
  sample_t      raw_i;
  sample_t      raw_q;
  logic         last_sample;
  iq_t          iq_pipe_q [DDS_LATENCY];
  logic         valid_pipe_q [DDS_LATENCY];

  assign chirp_ready_o  = (state_q == CHIRP_READY);
  assign chirp_active_o = (state_q == CHIRP_ACTIVE);
  assign chirp_done_o   = (state_q == CHIRP_DONE);

  // last sample of the sweep at one per active cycle
  assign last_sample = (sample_cnt_q + 1'b1) >= count_max_i;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state_q <= CHIRP_IDLE;
    end else begin
      case (state_q)
        CHIRP_IDLE, CHIRP_DONE: begin
          // re-arm from either resting state
          if (chirp_init_i) begin
            state_q <= CHIRP_READY;
          end
        end
        CHIRP_READY: begin
          if (chirp_enable_i) begin
            state_q <= CHIRP_ACTIVE;
          end
        end
        default: begin
          if (last_sample) begin
            state_q <= CHIRP_DONE;
          end
        end
      endcase
    end
  end

  // sweep starts at the offset with zero phase
  always_ff @(posedge clk_245_76MHz) begin
    if (chirp_ready_o && chirp_enable_i) begin
      phase_q      <= '0;
      tuning_q     <= freq_offset_i;
      sample_cnt_q <= '0;
    end else if (chirp_active_o) begin
      phase_q      <= phase_q + tuning_q;
      // linear frequency ramp
      tuning_q     <= tuning_q + tuning_coeff_i;
      sample_cnt_q <= sample_cnt_q + 1'b1;
    end
  end

  // sawtooth from the phase without a sine table
  assign raw_i = chirp_active_o ? sample_t'(phase_q[SAMPLE_LSB +: $bits(sample_t)]) : '0;
  assign raw_q = chirp_active_o ?
                 sample_t'(phase_q[SAMPLE_LSB +: $bits(sample_t)] + QUARTER_TURN) : '0;

  // output latency of the dds core
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      for (int s = 0; s < DDS_LATENCY; s++) begin
        iq_pipe_q[s]    <= '0;
        valid_pipe_q[s] <= 1'b0;
      end
    end else begin
      iq_pipe_q[0]    <= {raw_i, raw_q};
      valid_pipe_q[0] <= chirp_active_o;
      for (int s = 1; s < DDS_LATENCY; s++) begin
        iq_pipe_q[s]    <= iq_pipe_q[s-1];
        valid_pipe_q[s] <= valid_pipe_q[s-1];
      end
    end
  end

  assign dds_i_o     = sample_t'(iq_pipe_q[DDS_LATENCY-1][31:16]);
  assign dds_q_o     = sample_t'(iq_pipe_q[DDS_LATENCY-1][15:0]);
  assign dds_valid_o = valid_pipe_q[DDS_LATENCY-1];

  chirp_active_done_excl_a : assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    !(chirp_active_o && chirp_done_o)
  );

endmodule

/* rtl/adc_loopback.sv */
`timescale 1ns/1ps

module adc_loopback #(
  parameter int ADC_DELAY = 100
) (
  input  logic                   clk_245_76MHz,
  input  logic                   cpu_reset,
  input  chirp_dsp_pkg::sample_t dds_i_i,
  input  chirp_dsp_pkg::sample_t dds_q_i,
  input  logic                   dds_valid_i,
  output chirp_dsp_pkg::iq_t     dac_iq_o,
  output chirp_dsp_pkg::iq_t     adc_iq_o,
  output logic                   adc_valid_o
);

  import chirp_dsp_pkg::*;

  sample_t dac_i_r;
  sample_t dac_q_r;
  sample_t dac_i_rr;
  sample_t dac_q_rr;
  sample_t half_i;
  sample_t half_q;
  iq_t     delay_q [ADC_DELAY];

  // two register stages on the converter board dac path
  always_ff @(posedge clk_245_76MHz) begin
    dac_i_r  <= dds_valid_i ? dds_i_i : sample_t'(0);
    dac_q_r  <= dds_valid_i ? dds_q_i : sample_t'(0);
    dac_i_rr <= dac_i_r;
    dac_q_rr <= dac_q_r;
  end

  assign dac_iq_o = {dac_i_rr, dac_q_rr};

  // loop attenuation, sign kept
  assign half_i = dac_i_rr >>> 1;
  assign half_q = dac_q_rr >>> 1;

  // round-trip delay to the adc
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      for (int d = 0; d < ADC_DELAY; d++) begin
        delay_q[d] <= '0;
      end
    end else begin
      delay_q[0] <= {half_i, half_q};
      for (int d = 1; d < ADC_DELAY; d++) begin
        delay_q[d] <= delay_q[d-1];
      end
    end
  end

  assign adc_iq_o = delay_q[ADC_DELAY-1];

  // converter streams continuously once out of reset
  always_ff @(posedge clk_245_76MHz) begin
    adc_valid_o <= !cpu_reset;
  end

endmodule

/* rtl/capture_framer.sv */
`timescale 1ns/1ps

module capture_framer #(
  parameter int DDS_LATENCY = 2
) (
  input  logic                      clk_245_76MHz,
  input  logic                      cpu_reset,
  input  logic                      adc_enable_i,
  input  logic                      chirp_init_i,
  input  capture_pkg::half_word_t   control_word_i,
  input  chirp_dsp_pkg::iq_t        dac_iq_i,
  input  chirp_dsp_pkg::iq_t        adc_iq_i,
  input  logic                      adc_valid_i,
  output logic                      wr_en_o,
  output capture_pkg::capture_word_t wr_data_o,
  output logic                      wr_last_o
);

  import capture_pkg::*;

  localparam int CNT_W = $clog2(DDS_LATENCY + 1);

  logic             enable_r;
  logic             enable_rr;
  logic [CNT_W-1:0] latency_cnt_q;
  logic             latency_zero;
  logic             first_q;
  counter_t         adc_cnt_q;
  counter_t         glbl_cnt_q;
  route_sel_t       route_lo;
  route_sel_t       route_hi;
  half_word_t       data_lo;
  half_word_t       data_hi;

  function automatic half_word_t route_mux(
    input route_sel_t sel,
    input half_word_t adc_iq,
    input half_word_t dac_iq,
    input counter_t   adc_cnt,
    input counter_t   glbl_cnt
  );
    case (sel)
      ROUTE_ADC_IQ:    return adc_iq;
      ROUTE_DAC_IQ:    return dac_iq;
      ROUTE_ADC_COUNT: return adc_cnt;
      default:         return glbl_cnt;
    endcase
  endfunction

  assign latency_zero = (latency_cnt_q == '0);

  // window edges only move once the dds pipeline has drained
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_r  <= 1'b0;
      enable_rr <= 1'b0;
      first_q   <= 1'b0;
    end else begin
      enable_r <= adc_enable_i;
      if (latency_zero) begin
        enable_rr <= enable_r;
      end
      // opening edge of the window
      first_q <= latency_zero && enable_r && !enable_rr;
    end
  end

  // reload on a falling enable or a new chirp
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      latency_cnt_q <= '0;
    end else if (chirp_init_i || (enable_r && !adc_enable_i)) begin
      latency_cnt_q <= CNT_W'(DDS_LATENCY);
    end else if (!latency_zero) begin
      latency_cnt_q <= latency_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      adc_cnt_q  <= '0;
      glbl_cnt_q <= '0;
    end else begin
      glbl_cnt_q <= glbl_cnt_q + 1'b1;
      if (wr_en_o) begin
        adc_cnt_q <= adc_cnt_q + 1'b1;
      end
    end
  end

  // control word bits 1:0 and 5:4
  assign route_lo = route_sel_t'(control_word_i[ROUTE_LO_LSB +: $bits(route_sel_t)]);
  assign route_hi = route_sel_t'(control_word_i[ROUTE_HI_LSB +: $bits(route_sel_t)]);
  assign data_lo  = route_mux(route_lo, adc_iq_i, dac_iq_i, adc_cnt_q, glbl_cnt_q);
  assign data_hi  = route_mux(route_hi, adc_iq_i, dac_iq_i, adc_cnt_q, glbl_cnt_q);

  assign wr_en_o   = enable_rr && adc_valid_i;
  // closing edge, countdown expired
  assign wr_last_o = wr_en_o && latency_zero && !enable_r;

  // frame header {global count, adc count} at both ends
  assign wr_data_o = (first_q || wr_last_o) ? {glbl_cnt_q, adc_cnt_q} : {data_hi, data_lo};

  // a frame ends with its header and the window is shut next cycle
  frame_last_closes_a : assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    wr_last_o |-> wr_en_o ##1 !wr_en_o
  );

endmodule

/* rtl/capture_fifo.sv */
`timescale 1ns/1ps

module capture_fifo #(
  parameter int FIFO_DEPTH = 512
) (
  input  logic                       clk_245_76MHz,
  input  logic                       cpu_reset,
  input  logic                       wr_en_i,
  input  capture_pkg::capture_word_t wr_data_i,
  input  logic                       wr_last_i,
  input  logic                       rd_en_i,
  output capture_pkg::capture_word_t rd_data_o,
  output logic                       rd_last_o,
  output logic                       rd_empty_o,
  output logic                       overflow_o
);

  import capture_pkg::*;

  localparam int ADDR_W  = $clog2(FIFO_DEPTH);
  // data word plus the frame end flag
  localparam int ENTRY_W = $bits(capture_word_t) + 1;

  logic [ENTRY_W-1:0] mem_q [FIFO_DEPTH];
  logic [ADDR_W-1:0]  wr_ptr_q;
  logic [ADDR_W-1:0]  rd_ptr_q;
  logic [ADDR_W:0]    count_q;
  logic               full;
  logic               wr_ok;
  logic               rd_ok;

  if (FIFO_DEPTH != (1 << ADDR_W)) begin : g_depth_check
    $error("capture_fifo depth must be a power of two");
  end

  assign full       = (count_q == (ADDR_W + 1)'(FIFO_DEPTH));
  assign rd_empty_o = (count_q == '0);
  // no back-pressure upstream, words offered while full are lost
  assign wr_ok      = wr_en_i && !full;
  assign rd_ok      = rd_en_i && !rd_empty_o;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // sticky until reset
      if (wr_en_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (wr_ok) begin
      mem_q[wr_ptr_q] <= {wr_last_i, wr_data_i};
    end
  end

  // registered read port
  always_ff @(posedge clk_245_76MHz) begin
    if (rd_ok) begin
      {rd_last_o, rd_data_o} <= mem_q[rd_ptr_q];
    end
  end

  // the stream stage must not pull from an empty buffer
  no_read_when_empty_a : assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    rd_en_i |-> !rd_empty_o
  );

endmodule

/* rtl/axis_stream_out.sv */
`timescale 1ns/1ps

module axis_stream_out (
  input  logic                       clk_245_76MHz,
  input  logic                       cpu_reset,
  input  capture_pkg::capture_word_t rd_data_i,
  input  logic                       rd_last_i,
  input  logic                       rd_empty_i,
  input  logic                       axis_tready_i,
  output logic                       rd_en_o,
  output capture_pkg::capture_word_t axis_tdata_o,
  output logic                       axis_tlast_o,
  output logic                       axis_tvalid_o
);

  // fifo output holds a word not yet taken
  logic pending_q;
  logic load;

  // output register free or handing off this cycle
  assign load    = pending_q && (!axis_tvalid_o || axis_tready_i);
  // one read outstanding at most
  assign rd_en_o = !rd_empty_i && (!pending_q || load);

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      pending_q     <= 1'b0;
      axis_tvalid_o <= 1'b0;
    end else begin
      if (rd_en_o) begin
        pending_q <= 1'b1;
      end else if (load) begin
        pending_q <= 1'b0;
      end
      if (load) begin
        axis_tvalid_o <= 1'b1;
      end else if (axis_tready_i) begin
        axis_tvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (load) begin
      axis_tdata_o <= rd_data_i;
      axis_tlast_o <= rd_last_i;
    end
  end

  // stalled beat holds until accepted
  stall_hold_a : assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
    (axis_tvalid_o && !axis_tready_i) |=>
      (axis_tvalid_o && $stable(axis_tdata_o) && $stable(axis_tlast_o))
  );

endmodule

/* rtl/chirp_capture_top.sv */
`timescale 1ns/1ps

module chirp_capture_top #(
  parameter int DDS_LATENCY = 2,
  parameter int ADC_DELAY   = 100,
  parameter int FIFO_DEPTH  = 512
) (
  input  logic                        clk_245_76MHz,
  input  logic                        cpu_reset,
  input  logic                        chirp_init_i,
  input  logic                        chirp_enable_i,
  input  logic                        adc_enable_i,
  input  capture_pkg::half_word_t     chirp_control_word_i,
  input  chirp_dsp_pkg::tuning_word_t chirp_freq_offset_i,
  input  chirp_dsp_pkg::tuning_word_t chirp_tuning_word_coeff_i,
  input  capture_pkg::counter_t       chirp_count_max_i,
  input  logic                        axis_tready_i,
  output logic                        chirp_ready_o,
  output logic                        chirp_active_o,
  output logic                        chirp_done_o,
  output capture_pkg::capture_word_t  axis_tdata_o,
  output logic                        axis_tvalid_o,
  output logic                        axis_tlast_o,
  output logic                        fifo_overflow_o
);

  import chirp_dsp_pkg::*;
  import capture_pkg::*;

  // dds to converter model
  sample_t       dds_i;
  sample_t       dds_q;
  logic          dds_valid;
  // converter model to framer
  iq_t           dac_iq;
  iq_t           adc_iq;
  logic          adc_valid;
  // framer to buffer
  logic          wr_en;
  capture_word_t wr_data;
  logic          wr_last;
  // buffer to stream stage
  logic          rd_en;
  capture_word_t rd_data;
  logic          rd_last;
  logic          rd_empty;

  chirp_dds_gen #(
    .DDS_LATENCY(DDS_LATENCY)
  ) u_chirp_dds_gen (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .chirp_init_i  (chirp_init_i),
    .chirp_enable_i(chirp_enable_i),
    .freq_offset_i (chirp_freq_offset_i),
    .tuning_coeff_i(chirp_tuning_word_coeff_i),
    .count_max_i   (chirp_count_max_i),
    .dds_i_o       (dds_i),
    .dds_q_o       (dds_q),
    .dds_valid_o   (dds_valid),
    .chirp_ready_o (chirp_ready_o),
    .chirp_active_o(chirp_active_o),
    .chirp_done_o  (chirp_done_o)
  );

  adc_loopback #(
    .ADC_DELAY(ADC_DELAY)
  ) u_adc_loopback (
    .clk_245_76MHz(clk_245_76MHz),
    .cpu_reset    (cpu_reset),
    .dds_i_i      (dds_i),
    .dds_q_i      (dds_q),
    .dds_valid_i  (dds_valid),
    .dac_iq_o     (dac_iq),
    .adc_iq_o     (adc_iq),
    .adc_valid_o  (adc_valid)
  );

  capture_framer #(
    .DDS_LATENCY(DDS_LATENCY)
  ) u_capture_framer (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_enable_i  (adc_enable_i),
    .chirp_init_i  (chirp_init_i),
    .control_word_i(chirp_control_word_i),
    .dac_iq_i      (dac_iq),
    .adc_iq_i      (adc_iq),
    .adc_valid_i   (adc_valid),
    .wr_en_o       (wr_en),
    .wr_data_o     (wr_data),
    .wr_last_o     (wr_last)
  );

  capture_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_capture_fifo (
    .clk_245_76MHz(clk_245_76MHz),
    .cpu_reset    (cpu_reset),
    .wr_en_i      (wr_en),
    .wr_data_i    (wr_data),
    .wr_last_i    (wr_last),
    .rd_en_i      (rd_en),
    .rd_data_o    (rd_data),
    .rd_last_o    (rd_last),
    .rd_empty_o   (rd_empty),
    .overflow_o   (fifo_overflow_o)
  );

  axis_stream_out u_axis_stream_out (
    .clk_245_76MHz(clk_245_76MHz),
    .cpu_reset    (cpu_reset),
    .rd_data_i    (rd_data),
    .rd_last_i    (rd_last),
    .rd_empty_i   (rd_empty),
    .axis_tready_i(axis_tready_i),
    .rd_en_o      (rd_en),
    .axis_tdata_o (axis_tdata_o),
    .axis_tlast_o (axis_tlast_o),
    .axis_tvalid_o(axis_tvalid_o)
  );

endmodule

/* testbench/capture_checker.sv */
`timescale 1ns/1ps

module capture_checker #(
  parameter int ADC_DELAY = 100
) (
  input  logic                        clk_245_76MHz,
  input  logic                        cpu_reset,
  input  capture_pkg::half_word_t     control_word_i,
  input  chirp_dsp_pkg::tuning_word_t freq_offset_i,
  input  chirp_dsp_pkg::tuning_word_t tuning_coeff_i,
  input  capture_pkg::counter_t       count_max_i,
  input  int                          frame_len_i,
  input  capture_pkg::capture_word_t  axis_tdata_i,
  input  logic                        axis_tvalid_i,
  input  logic                        axis_tlast_i,
  input  logic                        axis_tready_i,
  input  logic                        chirp_ready_i,
  input  logic                        chirp_active_i,
  input  logic                        chirp_done_i,
  input  logic                        fifo_overflow_i,
  output int                          error_count_o,
  output int                          frame_count_o,
  output int                          word_count_o,
  output int                          chirp_count_o
);

  import chirp_dsp_pkg::*;
  import capture_pkg::*;

  localparam int MAX_WORDS = 512;

  // dac halves of the frame in flight by word position
  half_word_t    dac_seen [MAX_WORDS];
  int            pos;
  int            chirp_k;
  logic          chirp_frame;
  half_word_t    first_lo;
  half_word_t    first_hi;
  counter_t      next_adc;
  logic          in_reset_q;
  logic          active_q;
  int            active_len;
  logic          stall_q;
  capture_word_t stall_data_q;
  logic          stall_last_q;
  logic          overflow_seen;

  // expected dac word for chirp sample k
  function automatic half_word_t chirp_dac_word(
    input int           k,
    input tuning_word_t offset,
    input tuning_word_t coeff
  );
    tuning_word_t phase;
    tuning_word_t tune;
    logic [15:0]  i_v;
    logic [15:0]  q_v;
    phase = '0;
    tune  = offset;
    for (int j = 0; j < k; j++) begin
      phase = phase + tune;
      tune  = tune + coeff;
    end
    // sawtooth i, q a quarter turn ahead
    i_v = phase[31:16];
    q_v = i_v + 16'h4000;
    return {i_v, q_v};
  endfunction

  // loop attenuation on each channel by itself
  function automatic half_word_t halve_iq(input half_word_t iq);
    sample_t i_s;
    sample_t q_s;
    i_s = sample_t'(iq[31:16]);
    q_s = sample_t'(iq[15:0]);
    i_s = i_s >>> 1;
    q_s = q_s >>> 1;
    return {i_s, q_s};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("FAILED %s expected %h got %h at %0t", name, expected, actual, $time);
    error_count_o++;
  endtask

  task automatic report_problem(input string what);
    $display("error: %s at %0t", what, $time);
    error_count_o++;
  endtask

  task automatic check_reset_values();
    if (axis_tvalid_i !== 1'b0) report_mismatch("axis_tvalid_o", 0, axis_tvalid_i);
    if (chirp_ready_i !== 1'b0) report_mismatch("chirp_ready_o", 0, chirp_ready_i);
    if (chirp_active_i !== 1'b0) report_mismatch("chirp_active_o", 0, chirp_active_i);
    if (chirp_done_i !== 1'b0) report_mismatch("chirp_done_o", 0, chirp_done_i);
  endtask

  // active length against the programmed sample count
  task automatic track_chirp();
    if (chirp_active_i) active_len++;
    if (active_q && !chirp_active_i) begin
      if (counter_t'(active_len) !== count_max_i) begin
        report_mismatch("chirp_active_o cycles", count_max_i, active_len);
      end
      if (chirp_done_i !== 1'b1) report_mismatch("chirp_done_o", 1, chirp_done_i);
      chirp_count_o++;
      active_len = 0;
    end
    active_q = chirp_active_i;
  endtask

  // a stalled beat must come back unchanged
  task automatic check_stall();
    if (stall_q) begin
      if (axis_tvalid_i !== 1'b1) report_mismatch("axis_tvalid_o", 1, axis_tvalid_i);
      if (axis_tdata_i !== stall_data_q) begin
        report_mismatch("axis_tdata_o", stall_data_q, axis_tdata_i);
      end
      if (axis_tlast_i !== stall_last_q) begin
        report_mismatch("axis_tlast_o", stall_last_q, axis_tlast_i);
      end
    end
    stall_q      = axis_tvalid_i && !axis_tready_i;
    stall_data_q = axis_tdata_i;
    stall_last_q = axis_tlast_i;
  endtask

  task automatic check_chirp_word(input half_word_t lo, input half_word_t hi);
    half_word_t exp_dac;
    half_word_t exp_adc;
    if (pos < MAX_WORDS) dac_seen[pos] = lo;
    // i and q are never both zero inside a sweep so the first nonzero word is sample 0
    if (chirp_k < 0 && lo != '0) chirp_k = 0;
    if (chirp_k >= 0) begin
      exp_dac = '0;
      if (counter_t'(chirp_k) < count_max_i) begin
        exp_dac = chirp_dac_word(chirp_k, freq_offset_i, tuning_coeff_i);
      end
      if (lo !== exp_dac) report_mismatch("axis_tdata_o[31:0]", exp_dac, lo);
      chirp_k++;
    end
    // echo of the dac half ADC_DELAY words back
    if (pos > ADC_DELAY && pos < MAX_WORDS) begin
      exp_adc = halve_iq(dac_seen[pos - ADC_DELAY]);
      if (hi !== exp_adc) report_mismatch("axis_tdata_o[63:32]", exp_adc, hi);
    end
  endtask

  task automatic parse_word();
    half_word_t lo;
    half_word_t hi;
    route_sel_t lo_sel;
    route_sel_t hi_sel;
    lo     = axis_tdata_i[31:0];
    hi     = axis_tdata_i[63:32];
    lo_sel = route_sel_t'(control_word_i[ROUTE_LO_LSB +: 2]);
    hi_sel = route_sel_t'(control_word_i[ROUTE_HI_LSB +: 2]);
    word_count_o++;
    if (pos == 0) begin
      // opening header carries on the adc count of the last frame
      if (lo !== next_adc) report_mismatch("axis_tdata_o[31:0] header", next_adc, lo);
      first_lo    = lo;
      first_hi    = hi;
      chirp_k     = -1;
      chirp_frame = (lo_sel == ROUTE_DAC_IQ) && (hi_sel == ROUTE_ADC_IQ);
    end else if (axis_tlast_i || (lo_sel == ROUTE_ADC_COUNT && hi_sel == ROUTE_GLBL_COUNT)) begin
      // both counters step once per captured word
      if (lo !== half_word_t'(first_lo + pos)) begin
        report_mismatch("axis_tdata_o[31:0]", half_word_t'(first_lo + pos), lo);
      end
      if (hi !== half_word_t'(first_hi + pos)) begin
        report_mismatch("axis_tdata_o[63:32]", half_word_t'(first_hi + pos), hi);
      end
    end else if (chirp_frame) begin
      check_chirp_word(lo, hi);
    end
    if (axis_tlast_i) begin
      if (pos + 1 != frame_len_i) report_mismatch("axis_tlast_o word index", frame_len_i - 1, pos);
      if (chirp_frame && chirp_k < 0) report_problem("chirp frame held no chirp samples");
      next_adc = lo + 1'b1;
      frame_count_o++;
      pos = 0;
    end else begin
      pos++;
    end
  endtask

  always @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      in_reset_q    = 1'b1;
      error_count_o = 0;
      frame_count_o = 0;
      word_count_o  = 0;
      chirp_count_o = 0;
      pos           = 0;
      chirp_k       = -1;
      chirp_frame   = 1'b0;
      next_adc      = '0;
      active_q      = 1'b0;
      active_len    = 0;
      stall_q       = 1'b0;
      overflow_seen = 1'b0;
    end else begin
      // first edge out of reset sees the reset values
      if (in_reset_q) check_reset_values();
      in_reset_q = 1'b0;
      if (fifo_overflow_i !== 1'b0 && !overflow_seen) begin
        report_mismatch("fifo_overflow_o", 0, fifo_overflow_i);
        overflow_seen = 1'b1;
      end
      track_chirp();
      check_stall();
      if (axis_tvalid_i && axis_tready_i) parse_word();
    end
  end

endmodule

/* testbench/tb_chirp_capture.sv */
`timescale 1ns/1ps

module tb_chirp_capture;

  import chirp_dsp_pkg::*;
  import capture_pkg::*;

  localparam int DDS_LATENCY   = 2;
  localparam int ADC_DELAY     = 100;
  localparam int FIFO_DEPTH    = 512;
  localparam int CLK_PERIOD_NS = 40;
  // window lengths in cycles, a frame is two words longer
  localparam int LEN_A         = 60;
  localparam int LEN_B         = 200;
  localparam int LEN_C         = 120;
  localparam int LEN_D         = 200;
  localparam int TOTAL_WORDS   = LEN_A + LEN_B + LEN_C + LEN_D + 8;
  localparam int WATCHDOG_NS   = TOTAL_WORDS * 4 * CLK_PERIOD_NS + 20000;

  logic          clk_245_76MHz;
  logic          cpu_reset;
  logic          chirp_init_i;
  logic          chirp_enable_i;
  logic          adc_enable_i;
  half_word_t    chirp_control_word_i;
  tuning_word_t  chirp_freq_offset_i;
  tuning_word_t  chirp_tuning_word_coeff_i;
  counter_t      chirp_count_max_i;
  logic          axis_tready_i;
  logic          chirp_ready_o;
  logic          chirp_active_o;
  logic          chirp_done_o;
  capture_word_t axis_tdata_o;
  logic          axis_tvalid_o;
  logic          axis_tlast_o;
  logic          fifo_overflow_o;

  int            frame_len;
  logic          random_ready;
  integer        seed = 48;
  int            rnd_word;
  int            checker_errors;
  int            frame_count;
  int            word_count;
  int            chirp_count;
  int            tb_errors;

  always #(CLK_PERIOD_NS / 2) clk_245_76MHz = ~clk_245_76MHz;

  chirp_capture_top #(
    .DDS_LATENCY(DDS_LATENCY),
    .ADC_DELAY  (ADC_DELAY),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_chirp_capture_top (
    .clk_245_76MHz            (clk_245_76MHz),
    .cpu_reset                (cpu_reset),
    .chirp_init_i             (chirp_init_i),
    .chirp_enable_i           (chirp_enable_i),
    .adc_enable_i             (adc_enable_i),
    .chirp_control_word_i     (chirp_control_word_i),
    .chirp_freq_offset_i      (chirp_freq_offset_i),
    .chirp_tuning_word_coeff_i(chirp_tuning_word_coeff_i),
    .chirp_count_max_i        (chirp_count_max_i),
    .axis_tready_i            (axis_tready_i),
    .chirp_ready_o            (chirp_ready_o),
    .chirp_active_o           (chirp_active_o),
    .chirp_done_o             (chirp_done_o),
    .axis_tdata_o             (axis_tdata_o),
    .axis_tvalid_o            (axis_tvalid_o),
    .axis_tlast_o             (axis_tlast_o),
    .fifo_overflow_o          (fifo_overflow_o)
  );

  capture_checker #(
    .ADC_DELAY(ADC_DELAY)
  ) u_capture_checker (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .control_word_i (chirp_control_word_i),
    .freq_offset_i  (chirp_freq_offset_i),
    .tuning_coeff_i (chirp_tuning_word_coeff_i),
    .count_max_i    (chirp_count_max_i),
    .frame_len_i    (frame_len),
    .axis_tdata_i   (axis_tdata_o),
    .axis_tvalid_i  (axis_tvalid_o),
    .axis_tlast_i   (axis_tlast_o),
    .axis_tready_i  (axis_tready_i),
    .chirp_ready_i  (chirp_ready_o),
    .chirp_active_i (chirp_active_o),
    .chirp_done_i   (chirp_done_o),
    .fifo_overflow_i(fifo_overflow_o),
    .error_count_o  (checker_errors),
    .frame_count_o  (frame_count),
    .word_count_o   (word_count),
    .chirp_count_o  (chirp_count)
  );

  // sink back-pressure, ready about three cycles in four when random
  always @(posedge clk_245_76MHz) begin
    if (random_ready) begin
      rnd_word = $random(seed);
      axis_tready_i <= (rnd_word[1:0] != 2'b00);
    end else begin
      axis_tready_i <= 1'b1;
    end
  end

  // counter routes, adc count low and global count high
  task automatic run_count_frame(input int len);
    @(posedge clk_245_76MHz);
    chirp_control_word_i <= 32'h0000_0032;
    frame_len            <= len + 2;
    @(posedge clk_245_76MHz);
    adc_enable_i <= 1'b1;
    repeat (len) @(posedge clk_245_76MHz);
    adc_enable_i <= 1'b0;
  endtask

  // dac iq low, adc iq high, sweep starts inside the window
  task automatic run_chirp_frame(input int len, input tuning_word_t offset,
                                 input tuning_word_t coeff, input int samples);
    @(posedge clk_245_76MHz);
    chirp_control_word_i      <= 32'h0000_0001;
    chirp_freq_offset_i       <= offset;
    chirp_tuning_word_coeff_i <= coeff;
    chirp_count_max_i         <= samples;
    frame_len                 <= len + 2;
    chirp_init_i              <= 1'b1;
    @(posedge clk_245_76MHz);
    chirp_init_i <= 1'b0;
    // let the framer countdown run out first
    repeat (4) @(posedge clk_245_76MHz);
    adc_enable_i <= 1'b1;
    repeat (6) @(posedge clk_245_76MHz);
    chirp_enable_i <= 1'b1;
    @(posedge clk_245_76MHz);
    chirp_enable_i <= 1'b0;
    repeat (len - 7) @(posedge clk_245_76MHz);
    adc_enable_i <= 1'b0;
  endtask

  // done means the checker has seen tlast of frame n
  task automatic wait_frames(input int n);
    while (frame_count < n) @(posedge clk_245_76MHz);
    repeat (4) @(posedge clk_245_76MHz);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, frames still outstanding", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  initial begin
    clk_245_76MHz             = 1'b0;
    cpu_reset                 = 1'b1;
    chirp_init_i              = 1'b0;
    chirp_enable_i            = 1'b0;
    adc_enable_i              = 1'b0;
    chirp_control_word_i      = '0;
    chirp_freq_offset_i       = '0;
    chirp_tuning_word_coeff_i = '0;
    chirp_count_max_i         = '0;
    axis_tready_i             = 1'b1;
    random_ready              = 1'b0;
    frame_len                 = 0;
    tb_errors                 = 0;
    repeat (5) @(posedge clk_245_76MHz);
    cpu_reset <= 1'b0;
    repeat (4) @(posedge clk_245_76MHz);
    run_count_frame(LEN_A);
    wait_frames(1);
    run_chirp_frame(LEN_B, 32'h0100_0000, 32'h0004_0000, 48);
    wait_frames(2);
    random_ready <= 1'b1;
    run_count_frame(LEN_C);
    wait_frames(3);
    // downward ramp under back-pressure
    run_chirp_frame(LEN_D, 32'h0234_5678, 32'hFFF0_1234, 64);
    wait_frames(4);
    repeat (10) @(posedge clk_245_76MHz);
    if (chirp_count != 2) begin
      $display("error: expected 2 completed chirps, saw %0d", chirp_count);
      tb_errors++;
    end
    $display("frames %0d words %0d chirps %0d errors %0d", frame_count, word_count,
             chirp_count, checker_errors + tb_errors);
    if (checker_errors + tb_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* flist.f */
rtl/chirp_dsp_pkg.sv
rtl/capture_pkg.sv
rtl/chirp_dds_gen.sv
rtl/adc_loopback.sv
rtl/capture_framer.sv
rtl/capture_fifo.sv
rtl/axis_stream_out.sv
rtl/chirp_capture_top.sv
testbench/capture_checker.sv
testbench/tb_chirp_capture.sv
